//--- include/codec_defs.svh
`ifndef CODEC_DEFS_SVH
`define CODEC_DEFS_SVH

// bus geometry
`define CODEC_DATA_W     32
`define CODEC_ADDR_W     3

// largest code supported, (32,26) extended Hamming
`define CODEC_MAX_N      32
`define CODEC_MAX_K      26

`define CODEC_CNT_W      16  // event counters saturate at this width

// register word addresses
`define CODEC_REG_CTRL   3'd0
`define CODEC_REG_DATA   3'd1  // a write here launches a job
`define CODEC_REG_STATUS 3'd2
`define CODEC_REG_RESULT 3'd3
`define CODEC_REG_COUNT  3'd4  // any write clears both counters

// mode field codes, 3 is reserved
`define CODEC_MODE_8     2'd0
`define CODEC_MODE_16    2'd1
`define CODEC_MODE_32    2'd2

`endif

//--- design/codec_pkg.sv
`include "codec_defs.svh"

package codec_pkg;

    typedef logic [`CODEC_MAX_N-1:0] codeword_t;  // right-aligned, unused top bits zero
    typedef logic [`CODEC_MAX_K-1:0] info_t;

    typedef logic [1:0] mode_t;

    // one bit per power-of-two parity position
    typedef logic [$clog2(`CODEC_MAX_N)-1:0] syndrome_t;

    // 0 clean, 1 corrected, 2 uncorrectable
    typedef logic [1:0] err_status_t;

    typedef logic [`CODEC_CNT_W-1:0] count_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } ctrl_state_t;

endpackage

//--- design/codec_dp_if.sv
`timescale 1ns/10ps

interface codec_dp_if;

    codec_pkg::mode_t       mode;
    codec_pkg::codeword_t   din;
    logic                   enc_start;  // one-cycle pulses
    logic                   dec_start;

    logic                   enc_valid;
    codec_pkg::codeword_t   enc_cw;

    logic                   dec_valid;
    codec_pkg::info_t       dec_info;
    codec_pkg::err_status_t dec_status;

    modport ctrl (
        output mode, din, enc_start, dec_start,
        input  enc_valid, enc_cw, dec_valid, dec_info, dec_status
    );

    modport enc (
        input  mode, din, enc_start,
        output enc_valid, enc_cw
    );

    modport dec (
        input  mode, din, dec_start,
        output dec_valid, dec_info, dec_status
    );

endinterface

//--- design/codec_ctrl.sv
`timescale 1ns/10ps
`include "codec_defs.svh"

module codec_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`CODEC_ADDR_W-1:0] adr,
    input  logic [`CODEC_DATA_W-1:0] dat_w,
    output logic [`CODEC_DATA_W-1:0] dat_r,
    output logic                     ack,
    codec_dp_if.ctrl                 dp
);

    codec_pkg::ctrl_state_t  state;
    codec_pkg::mode_t        mode_q;
    codec_pkg::codeword_t    din_q;
    codec_pkg::err_status_t  status_q;
    codec_pkg::count_t       corr_cnt;
    codec_pkg::count_t       unc_cnt;
    logic [`CODEC_DATA_W-1:0] result_q;
    logic [`CODEC_DATA_W-1:0] rd_data;
    logic                    op;  // 0 encode, 1 decode
    logic                    req;
    logic                    busy;
    logic                    job_valid;
    logic                    enc_start_q;
    logic                    dec_start_q;

    assign req  = cyc && stb && !ack;  // ack drops after one cycle even if stb is held
    assign busy = (state != codec_pkg::IDLE);

    // only the valid of the launched operation closes the job
    assign job_valid = (state == codec_pkg::DONE) && (op ? dp.dec_valid : dp.enc_valid);

    assign dp.mode      = mode_q;
    assign dp.din       = din_q;
    assign dp.enc_start = enc_start_q;
    assign dp.dec_start = dec_start_q;

    always_comb begin
        rd_data = '0;
        case (adr)
            `CODEC_REG_CTRL:   rd_data = {23'd0, op, 6'd0, mode_q};
            `CODEC_REG_STATUS: rd_data = {29'd0, status_q, busy};
            `CODEC_REG_RESULT: rd_data = result_q;
            `CODEC_REG_COUNT:  rd_data = {unc_cnt, corr_cnt};
            default:           rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack    <= 1'b0;
            dat_r  <= '0;
            op     <= 1'b0;
            mode_q <= `CODEC_MODE_8;
        end else begin
            ack <= req;
            if (req && !we) begin
                dat_r <= rd_data;
            end
            // mode and op stay frozen while a job is in flight
            if (req && we && adr == `CODEC_REG_CTRL && !busy) begin
                op <= dat_w[8];
                if (dat_w[1:0] <= `CODEC_MODE_32) begin
                    mode_q <= dat_w[1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == codec_pkg::IDLE && req && we && adr == `CODEC_REG_DATA) begin
            din_q <= dat_w;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= codec_pkg::IDLE;
            enc_start_q <= 1'b0;
            dec_start_q <= 1'b0;
        end else begin
            enc_start_q <= 1'b0;
            dec_start_q <= 1'b0;
            case (state)
                codec_pkg::IDLE: begin
                    if (req && we && adr == `CODEC_REG_DATA) begin
                        state <= codec_pkg::RUN;
                    end
                end
                codec_pkg::RUN: begin
                    enc_start_q <= !op;
                    dec_start_q <= op;
                    state       <= codec_pkg::DONE;
                end
                codec_pkg::DONE: begin
                    if (job_valid) begin
                        state <= codec_pkg::IDLE;
                    end
                end
                default: state <= codec_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
            status_q <= '0;
            corr_cnt <= '0;
            unc_cnt  <= '0;
        end else begin
            if (job_valid) begin
                result_q <= op ? {{(`CODEC_DATA_W-`CODEC_MAX_K){1'b0}}, dp.dec_info} : dp.enc_cw;
                status_q <= op ? dp.dec_status : '0;
            end
            if (req && we && adr == `CODEC_REG_COUNT) begin
                corr_cnt <= '0;
                unc_cnt  <= '0;
            end else if (job_valid && op) begin
                if (dp.dec_status == 2'd1 && corr_cnt != '1) begin
                    corr_cnt <= corr_cnt + 1'b1;
                end
                if (dp.dec_status == 2'd2 && unc_cnt != '1) begin  // uncorrectable
                    unc_cnt <= unc_cnt + 1'b1;
                end
            end
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

    a_no_idle_valid: assert property (@(posedge clk) disable iff (rst)
        (dp.enc_valid || dp.dec_valid) |-> state != codec_pkg::IDLE);

    a_launch_mode: assert property (@(posedge clk) disable iff (rst)
        (state == codec_pkg::IDLE) ##1 (state != codec_pkg::IDLE) |-> mode_q != 2'd3);

endmodule

//--- design/ham_encoder.sv
`timescale 1ns/10ps
`include "codec_defs.svh"

module ham_encoder (
    input  logic     clk,
    input  logic     rst,
    codec_dp_if.enc  dp
);

    localparam int P_BITS = $bits(codec_pkg::syndrome_t);

    codec_pkg::codeword_t placed;
    codec_pkg::codeword_t cw_next;
    int                   cw_len;

    function automatic int code_len(input codec_pkg::mode_t m);
        case (m)
            `CODEC_MODE_8:  return 8;
            `CODEC_MODE_16: return 16;
            default:        return `CODEC_MAX_N;
        endcase
    endfunction

    assign cw_len = code_len(dp.mode);

    always_comb begin : build_cw
        int  j;
        logic p;
        j = 0;
        placed = '0;
        // info bits go to every non power-of-two position below n, lowest first
        for (int i = 1; i < `CODEC_MAX_N; i++) begin
            if (i < cw_len && (i & (i - 1)) != 0) begin
                placed[i] = dp.din[j];
                j++;
            end
        end
        cw_next = placed;
        for (int k = 0; k < P_BITS; k++) begin
            p = 1'b0;
            for (int i = 1; i < `CODEC_MAX_N; i++) begin
                if (((i >> k) & 1) != 0) begin
                    p ^= placed[i];
                end
            end
            if ((1 << k) < cw_len) begin
                cw_next[1 << k] = p;
            end
        end
        cw_next[0] = ^cw_next;  // overall parity over the whole word
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dp.enc_valid <= 1'b0;
        end else begin
            dp.enc_valid <= dp.enc_start;
        end
    end

    always_ff @(posedge clk) begin
        if (dp.enc_start) begin
            dp.enc_cw <= cw_next;
        end
    end

    a_even_parity: assert property (@(posedge clk) disable iff (rst)
        dp.enc_valid |-> (^dp.enc_cw) == 1'b0);

endmodule

//--- design/ham_decoder.sv
`timescale 1ns/10ps
`include "codec_defs.svh"

module ham_decoder (
    input  logic     clk,
    input  logic     rst,
    codec_dp_if.dec  dp
);

    codec_pkg::codeword_t   rx;
    codec_pkg::syndrome_t   syn;
    logic                   overall;
    int                     len_in;

    // stage one registers
    logic                   s1_valid;
    codec_pkg::codeword_t   s1_word;
    codec_pkg::syndrome_t   s1_syn;
    logic                   s1_overall;
    codec_pkg::mode_t       s1_mode;

    codec_pkg::codeword_t   fixed;
    codec_pkg::info_t       info;
    codec_pkg::err_status_t status;
    int                     len_s1;

    function automatic int code_len(input codec_pkg::mode_t m);
        case (m)
            `CODEC_MODE_8:  return 8;
            `CODEC_MODE_16: return 16;
            default:        return `CODEC_MAX_N;
        endcase
    endfunction

    assign len_in = code_len(dp.mode);
    assign len_s1 = code_len(s1_mode);

    always_comb begin : stage1_calc
        rx  = '0;
        syn = '0;
        for (int i = 0; i < `CODEC_MAX_N; i++) begin
            if (i < len_in && dp.din[i]) begin
                rx[i] = 1'b1;
                syn ^= codec_pkg::syndrome_t'(i);
            end
        end
        overall = ^rx;
    end

    always_ff @(posedge clk) begin
        if (dp.dec_start) begin
            s1_word    <= rx;
            s1_syn     <= syn;
            s1_overall <= overall;
            s1_mode    <= dp.mode;  // later stages follow the mode of this job
        end
    end

    always_comb begin : stage2_calc
        int j;
        fixed  = s1_word;
        status = codec_pkg::err_status_t'(0);
        if (s1_overall) begin
            // odd weight error, a zero syndrome points at bit 0
            fixed[s1_syn] = ~s1_word[s1_syn];
            status = codec_pkg::err_status_t'(1);
        end else if (s1_syn != '0) begin
            status = codec_pkg::err_status_t'(2);  // double error, word left as received
        end
        j = 0;
        info = '0;
        for (int i = 1; i < `CODEC_MAX_N; i++) begin
            if (i < len_s1 && (i & (i - 1)) != 0) begin
                info[j] = fixed[i];
                j++;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            dp.dec_valid <= 1'b0;
        end else begin
            s1_valid     <= dp.dec_start;
            dp.dec_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            dp.dec_info   <= info;
            dp.dec_status <= status;
        end
    end

    a_status_legal: assert property (@(posedge clk) disable iff (rst)
        dp.dec_valid |-> dp.dec_status != 2'd3);

endmodule

//--- design/hamming_codec.sv
`timescale 1ns/10ps
`include "codec_defs.svh"

module hamming_codec (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`CODEC_ADDR_W-1:0] adr,
    input  logic [`CODEC_DATA_W-1:0] dat_w,
    output logic [`CODEC_DATA_W-1:0] dat_r,
    output logic                     ack
);

    codec_dp_if u_dp ();

    // bus slave and job sequencer
    codec_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .dp    (u_dp.ctrl)
    );

    ham_encoder u_encoder (
        .clk (clk),
        .rst (rst),
        .dp  (u_dp.enc)
    );

    ham_decoder u_decoder (
        .clk (clk),
        .rst (rst),
        .dp  (u_dp.dec)
    );

endmodule

//--- tb/tb_hamming_codec.sv
`timescale 1ns/10ps
`include "codec_defs.svh"

module tb_hamming_codec;

    typedef struct packed {
        logic [1:0]  mode;
        logic        op;
        logic [31:0] data;
        logic [31:0] flip1;
        logic [31:0] flip2;
        logic [31:0] exp_result;
        logic [1:0]  exp_status;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`CODEC_ADDR_W-1:0] adr;
    logic [`CODEC_DATA_W-1:0] dat_w;
    logic [`CODEC_DATA_W-1:0] dat_r;
    logic                     ack;

    row_t        rows[$];
    logic [31:0] rng;
    logic [31:0] rd;
    logic [31:0] first_info;
    logic [15:0] exp_corr;
    logic [15:0] exp_unc;

    hamming_codec u_hamming_codec (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int code_length(input logic [1:0] mode);
        case (mode)
            2'd0:    return 8;
            2'd1:    return 16;
            default: return 32;
        endcase
    endfunction

    function automatic logic [31:0] info_mask(input logic [1:0] mode);
        case (mode)
            2'd0:    return 32'h0000000f;
            2'd1:    return 32'h000007ff;
            default: return 32'h03ffffff;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] model_encode(input logic [1:0] mode, input logic [31:0] info);
        int          n;
        int          j;
        logic [31:0] cw;
        n = code_length(mode);
        j = 0;
        cw = '0;
        for (int i = 3; i < n; i++) begin
            if ((i & (i - 1)) != 0) begin  // skip the power-of-two parity slots
                cw[i] = info[j];
                j++;
            end
        end
        for (int p = 1; p < n; p = p * 2) begin
            for (int i = p + 1; i < n; i++) begin
                if ((i & p) != 0) begin
                    cw[p] = cw[p] ^ cw[i];
                end
            end
        end
        cw[0] = ^cw;
        return cw;
    endfunction

    // returns status in bits 27:26 and the info bits below
    function automatic logic [27:0] model_decode(input logic [1:0] mode, input logic [31:0] word);
        int          n;
        int          j;
        int          syn;
        logic        overall;
        logic [1:0]  status;
        logic [25:0] info;
        logic [31:0] w;
        n = code_length(mode);
        syn = 0;
        overall = 1'b0;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[i] = word[i];
            if (word[i]) begin
                syn = syn ^ i;
                overall = ~overall;
            end
        end
        status = 2'd0;
        if (overall) begin
            w[syn] = ~w[syn];
            status = 2'd1;
        end else if (syn != 0) begin
            status = 2'd2;
        end
        j = 0;
        info = '0;
        for (int i = 3; i < n; i++) begin
            if ((i & (i - 1)) != 0) begin
                info[j] = w[i];
                j++;
            end
        end
        return {status, info};
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, msg, got, exp);
            stop_with_failure();
        end
    endtask

    // called 2 ns after a rising edge, returns at the same point of the ack cycle
    task automatic wb_access(input logic write, input logic [2:0] a, input logic [31:0] d,
                             output logic [31:0] q);
        int waited;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = a;
        dat_w = d;
        waited = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!ack && waited < 20);
        if (!ack) begin
            $display("no bus acknowledge at register %0d", a);
            stop_with_failure();
        end
        q = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] a, input logic [31:0] d);
        logic [31:0] unused;
        wb_access(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input logic [2:0] a, output logic [31:0] q);
        wb_access(1'b0, a, 32'd0, q);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int          polls;
        polls = 0;
        st = 32'd1;
        while (st[0] && polls < 50) begin
            wb_read(`CODEC_REG_STATUS, st);
            polls++;
        end
        if (st[0]) begin
            $display("job still busy after %0d status polls", polls);
            stop_with_failure();
        end
    endtask

    task automatic add_row(input logic [1:0] mode, input logic op, input logic [31:0] data,
                           input logic [31:0] f1, input logic [31:0] f2,
                           input logic [31:0] exp_result, input logic [1:0] exp_status);
        row_t r;
        r.mode = mode;
        r.op = op;
        r.data = data;
        r.flip1 = f1;
        r.flip2 = f2;
        r.exp_result = exp_result;
        r.exp_status = exp_status;
        rows.push_back(r);
    endtask

    task automatic fill_table();
        logic [1:0]  md;
        logic [31:0] r;
        logic [31:0] junk;
        logic [31:0] cw;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [27:0] dec_out;
        int          n;
        int          p1;
        int          p2;
        for (int m = 0; m < 3; m++) begin
            md = m[1:0];
            n = code_length(md);
            add_row(md, 1'b0, 32'd0, 0, 0, model_encode(md, 32'd0), 2'd0);
            add_row(md, 1'b0, 32'hffffffff, 0, 0, model_encode(md, 32'hffffffff), 2'd0);
            for (int t = 0; t < 2; t++) begin
                draw(r);  // full 32-bit word, bits above k must be ignored
                add_row(md, 1'b0, r, 0, 0, model_encode(md, r), 2'd0);
            end
            for (int t = 0; t < 2; t++) begin
                draw(r);
                draw(junk);
                cw = model_encode(md, r);
                if (n < 32) begin
                    cw = cw | (junk << n);  // garbage above n
                end
                add_row(md, 1'b1, cw, 0, 0, r & info_mask(md), 2'd0);
            end
            for (int t = 0; t < 3; t++) begin
                draw(r);
                cw = model_encode(md, r);
                p1 = (t == 0) ? 0 : (t == 1) ? n - 1 : int'(rng[7:0]) % n;
                add_row(md, 1'b1, cw, 32'd1 << p1, 0, r & info_mask(md), 2'd1);
            end
            for (int t = 0; t < 2; t++) begin
                draw(r);
                cw = model_encode(md, r);
                p1 = int'(rng[7:0]) % n;
                p2 = (p1 + 1 + int'(rng[15:8]) % (n - 1)) % n;
                f1 = 32'd1 << p1;
                f2 = 32'd1 << p2;
                dec_out = model_decode(md, cw ^ f1 ^ f2);
                add_row(md, 1'b1, cw, f1, f2, {6'd0, dec_out[25:0]}, 2'd2);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        rng = 32'h6671;
        exp_corr = '0;
        exp_unc = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // every register and the unmapped space read zero out of reset
        for (int a = 0; a < 8; a++) begin
            wb_read(a[2:0], rd);
            check_eq(rd, 32'd0, $sformatf("reset value at register %0d", a));
        end

        fill_table();
        foreach (rows[i]) begin
            wb_write(`CODEC_REG_CTRL, {23'd0, rows[i].op, 6'd0, rows[i].mode});
            wb_write(`CODEC_REG_DATA, rows[i].data ^ rows[i].flip1 ^ rows[i].flip2);
            wait_idle();
            wb_read(`CODEC_REG_RESULT, rd);
            check_eq(rd, rows[i].exp_result, $sformatf("row %0d result", i));
            wb_read(`CODEC_REG_STATUS, rd);
            check_eq(rd, {29'd0, rows[i].exp_status, 1'b0}, $sformatf("row %0d status", i));
            if (rows[i].exp_status == 2'd1) begin
                exp_corr = exp_corr + 16'd1;
            end else if (rows[i].exp_status == 2'd2) begin
                exp_unc = exp_unc + 16'd1;
            end
            wb_read(`CODEC_REG_COUNT, rd);
            check_eq(rd, {exp_unc, exp_corr}, $sformatf("row %0d counters", i));
        end

        wb_write(`CODEC_REG_COUNT, 32'd0);
        wb_read(`CODEC_REG_COUNT, rd);
        check_eq(rd, 32'd0, "counters after clear");

        // reserved mode code keeps the previous mode
        wb_write(`CODEC_REG_CTRL, {30'd0, `CODEC_MODE_16});
        wb_write(`CODEC_REG_CTRL, 32'd3);
        wb_read(`CODEC_REG_CTRL, rd);
        check_eq(rd, 32'd1, "mode after reserved code write");

        // second DATA write lands while the first job is in flight
        draw(first_info);
        wb_write(`CODEC_REG_DATA, first_info);
        wb_write(`CODEC_REG_DATA, ~first_info);
        wait_idle();
        wb_read(`CODEC_REG_RESULT, rd);
        check_eq(rd, model_encode(`CODEC_MODE_16, first_info), "result with write while busy");

        $display("Regression passed");
        $finish;
    end

endmodule

//--- hamming_codec.f
+incdir+include
design/codec_pkg.sv
design/codec_dp_if.sv
design/codec_ctrl.sv
design/ham_encoder.sv
design/ham_decoder.sv
design/hamming_codec.sv
tb/tb_hamming_codec.sv

//--- run.sh
#!/bin/sh
# build and run the hamming codec regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hamming_codec \
    -f hamming_codec.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
